// File: divq_assert.sv
/* Handshake and reset checks for the control block, bound into every divq_ctrl.
   Only the control side is covered, data values are not */
module divq_assert (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  flush_i,
  input logic                  core_start_i,
  input logic                  core_ready_i,
  input logic                  res_valid_i,
  input logic                  res_ready_i,
  input logic                  busy_i,
  input divq_pkg::ctrl_state_e state_i
);

  import divq_pkg::*;

  // An offered result waits for the output side, flush excepted
  res_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    res_valid_i && !res_ready_i |=> res_valid_i)
    else $error("res_valid dropped before res_ready");

  // The core only takes work while idle and then leaves idle
  start_when_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_start_i |=> $past(core_ready_i) && !core_ready_i)
    else $error("core start issued while core not ready or not taken by the core");

  // Reset leaves the FSM idle with nothing offered
  reset_idle: assert property (@(posedge clk_i)
    !rst_ni |=> state_i == IDLE && !res_valid_i && !busy_i)
    else $error("control outputs active after reset");

endmodule

bind divq_ctrl divq_assert u_assert (
  .clk_i, .rst_ni, .flush_i,
  .core_start_i (core_start_o), .core_ready_i (core_ready_i),
  .res_valid_i (res_valid_o), .res_ready_i (res_ready_i),
  .busy_i (busy_o), .state_i (state_q)
);

// File: divq_core.sv
/* Unsigned restoring divider, one quotient bit per cycle, Width of at least 2.
   Outputs are valid only while done_o is high; kill drops the operation silently */
`include "divq_macros.svh"

module divq_core #(
  parameter int unsigned Width = `DIVQ_DATA_W
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  logic              kill_i,
  input  logic [Width-1:0]  dividend_i,
  input  logic [Width-1:0]  divisor_i,
  output logic              ready_o,
  output logic              done_o,
  output logic [Width-1:0]  quotient_o,
  output divq_pkg::status_t status_o
);

  import divq_pkg::*;

  localparam int unsigned CntW = $clog2(Width + 1);

  // ----------------------------------------------------------------------
  // State
  // ----------------------------------------------------------------------
  logic             busy_q;
  // Number of iterations already done
  logic [CntW-1:0]  count_q;
  logic             last_step;
  // Partial remainder
  logic [Width-1:0] rem_q;
  // Dividend bits shift out at the top, quotient bits shift in at the bottom
  logic [Width-1:0] quo_q;
  logic [Width-1:0] div_q;
  logic [Width:0]   rem_shift;
  logic [Width:0]   rem_diff;
  logic             take;
  status_t          status;

  assign last_step = (count_q == CntW'(Width));

  // ----------------------------------------------------------------------
  // One restoring step
  // ----------------------------------------------------------------------
  // Bring down the next dividend bit
  assign rem_shift = {rem_q, quo_q[Width-1]};
  assign rem_diff  = rem_shift - {1'b0, div_q};
  // Subtract only if the remainder does not go negative
  // a zero divisor always subtracts, so the quotient ends all ones
  assign take      = (rem_shift >= {1'b0, div_q});

  // Control, kill has priority over everything
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      count_q <= '0;
    end else if (kill_i) begin
      busy_q <= 1'b0;
    end else if (start_i && !busy_q) begin
      busy_q  <= 1'b1;
      count_q <= '0;
    end else if (busy_q) begin
      if (last_step) begin
        // Done cycle, back to idle at this edge
        busy_q <= 1'b0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Datapath
  always_ff @(posedge clk_i) begin
    if (start_i && !busy_q) begin
      rem_q <= '0;
      quo_q <= dividend_i;
      div_q <= divisor_i;
    end else if (busy_q && !last_step) begin
      rem_q <= take ? rem_diff[Width-1:0] : rem_shift[Width-1:0];
      quo_q <= {quo_q[Width-2:0], take};
    end
  end

  // ----------------------------------------------------------------------
  // Result
  // ----------------------------------------------------------------------
  always_comb begin
    status.dz = ~|div_q;
    // With a zero divisor the remainder equals the dividend
    status.nx = |rem_q;
  end

  assign ready_o    = ~busy_q;
  // No done in the cycle a kill lands
  assign done_o     = busy_q & last_step & ~kill_i;
  assign quotient_o = quo_q;
  assign status_o   = status;

endmodule

// File: divq_ctrl.sv
/* Control between input pipe, divider core and output pipe. Only one item is in the core
   at a time; the input is acked solely in the cycle the core starts */
`include "divq_macros.svh"

module divq_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   inp_valid_i,
  output logic                   inp_ready_o,
  input  logic [`DIVQ_TAG_W-1:0] tag_i,
  output logic                   core_start_o,
  input  logic                   core_ready_i,
  input  logic                   core_done_i,
  input  logic [`DIVQ_DATA_W-1:0] core_quotient_i,
  input  divq_pkg::status_t      core_status_i,
  output logic                   res_valid_o,
  input  logic                   res_ready_i,
  output logic [`DIVQ_DATA_W-1:0] res_quotient_o,
  output divq_pkg::status_t      res_status_o,
  output logic [`DIVQ_TAG_W-1:0] res_tag_o,
  output logic                   busy_o
);

  import divq_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  // Park the core result this cycle
  logic        hold_load;
  // Result comes from the hold register
  logic        data_held;

  logic [`DIVQ_TAG_W-1:0]  tag_q;
  logic [`DIVQ_DATA_W-1:0] held_quotient_q;
  status_t                 held_status_q;

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------
  always_comb begin
    inp_ready_o = 1'b0;
    res_valid_o = 1'b0;
    hold_load   = 1'b0;
    data_held   = 1'b0;
    busy_o      = 1'b0;
    state_d     = state_q;

    unique case (state_q)
      IDLE: begin
        if (inp_valid_i && core_ready_i) begin
          inp_ready_o = 1'b1;
          state_d     = BUSY;
        end
      end
      BUSY: begin
        busy_o = 1'b1;
        if (core_done_i) begin
          // Offer straight from the core
          res_valid_o = 1'b1;
          if (res_ready_i) begin
            state_d = IDLE;
          end else begin
            hold_load = 1'b1;
            state_d   = HOLD;
          end
        end
      end
      HOLD: begin
        busy_o      = 1'b1;
        data_held   = 1'b1;
        res_valid_o = 1'b1;
        if (res_ready_i) begin
          state_d = IDLE;
          if (inp_valid_i && core_ready_i) begin
            inp_ready_o = 1'b1;
            state_d     = BUSY;
          end
        end
      end
      default: state_d = IDLE;
    endcase

    // Flush cancels whatever was decided above
    if (flush_i) begin
      inp_ready_o = 1'b0;
      res_valid_o = 1'b0;
      hold_load   = 1'b0;
      busy_o      = 1'b0;
      state_d     = IDLE;
    end
  end

  // Input ack and core start are the same event
  assign core_start_o = inp_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------------------
  // Tag and hold registers
  // ----------------------------------------------------------------------
  // Tag follows the item that starts
  always_ff @(posedge clk_i) begin
    if (core_start_o) begin
      tag_q <= tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hold_load) begin
      held_quotient_q <= core_quotient_i;
      held_status_q   <= core_status_i;
    end
  end

  // Held data has priority in HOLD
  assign res_quotient_o = data_held ? held_quotient_q : core_quotient_i;
  assign res_status_o   = data_held ? held_status_q : core_status_i;
  assign res_tag_o      = tag_q;

endmodule

// File: divq_macros.svh
/* Defaults shared by the RTL and the testbench. The data width must be at least 2 and the
   tag width at least 1. Either register count may be 0 */
`ifndef DIVQ_MACROS_SVH
`define DIVQ_MACROS_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------
// Operand and quotient width, also the core iteration count
`define DIVQ_DATA_W 16
// Tag carried alongside each operation
`define DIVQ_TAG_W 4

// ----------------------------------------------------------------------
// Pipeline depth
// ----------------------------------------------------------------------
// Elastic stages before the control block
`define DIVQ_INP_REGS 1
// Elastic stages after the control block
`define DIVQ_OUT_REGS 1

`endif

// File: divq_pipe_regs.sv
/* Elastic register chain with valid/ready and synchronous flush.
   Ready is combinational through all stages; NumRegs of 0 gives plain wires */
module divq_pipe_regs #(
  parameter int unsigned Width   = 1,
  parameter int unsigned NumRegs = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic [Width-1:0] in_data_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic [Width-1:0] out_data_o,
  output logic             any_valid_o
);

  // Index i holds the item after i register stages
  logic [Width-1:0] data_q [0:NumRegs];
  logic [0:NumRegs] valid_q;
  // Ready of stage i, the last one comes from downstream
  logic [0:NumRegs] ready;

  // Stage 0 is the input port itself
  assign data_q[0]  = in_data_i;
  assign valid_q[0] = in_valid_i;
  assign in_ready_o = ready[0];

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic load;

    // Advance when the next stage takes data or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    // Payload moves only with a real item
    assign load = ready[i] & valid_q[i];

    // Flush wins over a load
    always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  // Last stage faces downstream
  assign ready[NumRegs] = out_ready_i;
  assign out_valid_o    = valid_q[NumRegs];
  assign out_data_o     = data_q[NumRegs];

  // Any registered stage holding an item, input port excluded
  always_comb begin
    any_valid_o = 1'b0;
    for (int i = 1; i <= NumRegs; i++) begin
      any_valid_o = any_valid_o | valid_q[i];
    end
  end

endmodule

// File: divq_pkg.sv
/* Types shared by the divider RTL, testbench and assertions.
   Status is two flags only, no remainder is returned */
package divq_pkg;

  // ----------------------------------------------------------------------
  // Result status
  // ----------------------------------------------------------------------
  // dz set on a zero divisor
  // nx set when the final remainder is nonzero
  typedef struct packed {
    logic dz;
    logic nx;
  } status_t;

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  // IDLE waits for work, BUSY has the core running,
  // HOLD parks a finished result until downstream takes it
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    HOLD = 2'd2
  } ctrl_state_e;

endpackage

// File: divq_tb.sv
/* Testbench for divq_top at the macro default widths. Inputs change on the falling edge,
   results are checked in order against a reference model of the divider */
`include "divq_macros.svh"

module divq_tb;

  import divq_pkg::*;

  localparam int unsigned W = `DIVQ_DATA_W;
  localparam int unsigned T = `DIVQ_TAG_W;
  // Longest wait for one input handshake, in cycles
  localparam int unsigned MaxWait = 400;

  logic         clk;
  logic         rst_n;
  logic         flush;
  logic         in_valid;
  logic         in_ready;
  logic [W-1:0] dividend;
  logic [W-1:0] divisor;
  logic [T-1:0] tag;
  logic         out_valid;
  logic         out_ready;
  logic [W-1:0] quotient;
  status_t      status;
  logic [T-1:0] tag_out;
  logic         busy;

  // Expected results in issue order
  logic [W-1:0] exp_quo_q [$];
  status_t      exp_sta_q [$];
  logic [T-1:0] exp_tag_q [$];

  int unsigned  value_errors;
  int unsigned  other_errors;
  integer       seed;
  integer       bp_seed;
  // 0 keeps out_ready high, 1 randomizes it, 2 holds it low
  int unsigned  ready_mode;
  logic [T-1:0] next_tag;

  divq_tb_clk u_clk (.clk_o(clk), .rst_no(rst_n));

  divq_top DUT (
    .clk_i(clk), .rst_ni(rst_n), .flush_i(flush),
    .in_valid_i(in_valid), .in_ready_o(in_ready),
    .dividend_i(dividend), .divisor_i(divisor), .tag_i(tag),
    .out_valid_o(out_valid), .out_ready_i(out_ready),
    .quotient_o(quotient), .status_o(status), .tag_o(tag_out),
    .busy_o(busy)
  );

  // ----------------------------------------------------------------------
  // Reference model and compare tasks
  // ----------------------------------------------------------------------
  function automatic void divq_ref(input logic [W-1:0] a, input logic [W-1:0] b,
                                   output logic [W-1:0] q, output status_t s);
    // Zero divisor saturates the quotient
    if (b == '0) begin
      q    = '1;
      s.dz = 1'b1;
      s.nx = (a != '0);
    end else begin
      q    = a / b;
      s.dz = 1'b0;
      s.nx = ((a % b) != '0);
    end
  endfunction

  task automatic check_quotient(input logic [W-1:0] got, input logic [W-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t: quotient %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_status(input status_t got, input status_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t: status dz/nx %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_tag(input logic [T-1:0] got, input logic [T-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t: tag %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus tasks, each entered and left on a falling edge
  // ----------------------------------------------------------------------
  task automatic send_item(input logic [W-1:0] a, input logic [W-1:0] b);
    logic [W-1:0] q;
    status_t      s;
    int unsigned  waited;
    bit           taken;
    divq_ref(a, b, q, s);
    waited   = 0;
    taken    = 1'b0;
    dividend = a;
    divisor  = b;
    tag      = next_tag;
    in_valid = 1'b1;
    while (!taken && waited < MaxWait) begin
      @(posedge clk);
      // in_ready still shows the value from before this edge
      if (in_ready) begin
        taken = 1'b1;
        exp_quo_q.push_back(q);
        exp_sta_q.push_back(s);
        exp_tag_q.push_back(next_tag);
      end
      waited++;
    end
    @(negedge clk);
    in_valid = 1'b0;
    if (taken) begin
      next_tag++;
    end else begin
      other_errors++;
      $display("Timeout: the input port never accepted the item with tag %h", next_tag);
    end
  endtask

  task automatic send_random();
    logic [31:0] r;
    logic [31:0] d;
    r = $random(seed);
    d = $random(seed);
    // Random shift mixes large, small and zero divisors
    send_item(r[W-1:0], d[W-1:0] >> d[31:28]);
  endtask

  // Outstanding results delivered and nothing left in flight
  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while ((exp_tag_q.size() != 0 || busy) && waited < 20 * MaxWait) begin
      @(negedge clk);
      waited++;
    end
    if (exp_tag_q.size() != 0 || busy) begin
      other_errors++;
      $display("Timeout: %0d results outstanding or busy_o still high", exp_tag_q.size());
    end
  endtask

  // ----------------------------------------------------------------------
  // Output side: ready driver and scoreboard
  // ----------------------------------------------------------------------
  always @(negedge clk) begin
    logic [31:0] r;
    r = $random(bp_seed);
    case (ready_mode)
      0:       out_ready = 1'b1;
      1:       out_ready = r[0];
      default: out_ready = 1'b0;
    endcase
  end

  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (exp_tag_q.size() == 0) begin
        other_errors++;
        $display("Unexpected result with tag %h while no item was outstanding", tag_out);
      end else begin
        check_quotient(quotient, exp_quo_q.pop_front());
        check_status(status, exp_sta_q.pop_front());
        check_tag(tag_out, exp_tag_q.pop_front());
      end
    end
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    int unsigned waited;
    seed         = 32'hb98721b8;
    bp_seed      = ~seed;
    flush        = 1'b0;
    in_valid     = 1'b0;
    dividend     = '0;
    divisor      = '0;
    tag          = '0;
    out_ready    = 1'b1;
    ready_mode   = 0;
    next_tag     = '0;
    value_errors = 0;
    other_errors = 0;
    waited       = 0;
    while (!rst_n && waited < MaxWait) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) begin
      other_errors++;
      $display("Timeout: reset was never released");
    end
    @(negedge clk);
    check_flag(out_valid, 1'b0, "out_valid_o after reset");
    check_flag(busy, 1'b0, "busy_o after reset");
    check_flag(in_ready, 1'b1, "in_ready_o after reset");

    // Random pairs with the output always ready
    repeat (40) send_random();
    wait_drain();

    // Zero divisors and exact divisions
    send_item(W'(100), '0);
    send_item('0, '0);
    send_item(W'(144), W'(12));
    send_item(W'(145), W'(12));
    send_item('1, W'(1));
    send_item(W'(7), W'(9));
    wait_drain();

    // Random back-pressure on the output
    ready_mode = 1;
    repeat (40) send_random();
    wait_drain();

    // Items in the output pipe, the core and the input pipe, then flush
    ready_mode = 2;
    repeat (3) send_random();
    flush = 1'b1;
    exp_quo_q.delete();
    exp_sta_q.delete();
    exp_tag_q.delete();
    @(negedge clk);
    flush      = 1'b0;
    ready_mode = 0;
    wait_drain();
    repeat (12) send_random();
    wait_drain();

    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Last resort against a stuck run
  initial begin
    #4000000;
    $display("Watchdog expired before the test sequence finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: divq_tb_clk.sv
/* Testbench clock of period 20 and an active-low reset that stays low for 8 rising edges.
   Reset is released on a falling edge */
module divq_tb_clk (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release well away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: divq_top.sv
/* Tagged integer divider: input pipe, control, iterative core, output pipe.
   Latency depends on the register counts and on back-pressure; out_valid_o marks results */
`include "divq_macros.svh"

module divq_top #(
  parameter int unsigned NumInpRegs = `DIVQ_INP_REGS,
  parameter int unsigned NumOutRegs = `DIVQ_OUT_REGS
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  logic [`DIVQ_DATA_W-1:0] dividend_i,
  input  logic [`DIVQ_DATA_W-1:0] divisor_i,
  input  logic [`DIVQ_TAG_W-1:0]  tag_i,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic [`DIVQ_DATA_W-1:0] quotient_o,
  output divq_pkg::status_t       status_o,
  output logic [`DIVQ_TAG_W-1:0]  tag_o,
  output logic                    busy_o
);

  import divq_pkg::*;

  localparam int unsigned InpW = 2 * `DIVQ_DATA_W + `DIVQ_TAG_W;
  localparam int unsigned OutW = `DIVQ_DATA_W + $bits(status_t) + `DIVQ_TAG_W;

  // ----------------------------------------------------------------------
  // Internal nets
  // ----------------------------------------------------------------------
  logic [InpW-1:0] inp_data;
  logic [OutW-1:0] out_data;
  logic            inp_valid, inp_ready, inp_any;
  logic [`DIVQ_DATA_W-1:0] dividend, divisor;
  logic [`DIVQ_TAG_W-1:0]  tag;
  logic                    core_start, core_ready, core_done;
  logic [`DIVQ_DATA_W-1:0] core_quotient;
  status_t                 core_status;
  logic                    res_valid, res_ready;
  logic [`DIVQ_DATA_W-1:0] res_quotient;
  status_t                 res_status;
  logic [`DIVQ_TAG_W-1:0]  res_tag;
  logic                    ctrl_busy, out_any;

  // Operands and tag travel as one word
  divq_pipe_regs #(.Width(InpW), .NumRegs(NumInpRegs)) u_inp_pipe (
    .clk_i, .rst_ni, .flush_i,
    .in_valid_i, .in_ready_o,
    .in_data_i   ({dividend_i, divisor_i, tag_i}),
    .out_valid_o (inp_valid),
    .out_ready_i (inp_ready),
    .out_data_o  (inp_data),
    .any_valid_o (inp_any)
  );
  assign {dividend, divisor, tag} = inp_data;

  divq_ctrl u_ctrl (
    .clk_i, .rst_ni, .flush_i,
    .inp_valid_i (inp_valid), .inp_ready_o (inp_ready), .tag_i (tag),
    .core_start_o (core_start), .core_ready_i (core_ready), .core_done_i (core_done),
    .core_quotient_i (core_quotient), .core_status_i (core_status),
    .res_valid_o (res_valid), .res_ready_i (res_ready),
    .res_quotient_o (res_quotient), .res_status_o (res_status), .res_tag_o (res_tag),
    .busy_o (ctrl_busy)
  );

  // Core is killed by the same flush
  divq_core #(.Width(`DIVQ_DATA_W)) u_core (
    .clk_i, .rst_ni,
    .start_i (core_start), .kill_i (flush_i),
    .dividend_i (dividend), .divisor_i (divisor),
    .ready_o (core_ready), .done_o (core_done),
    .quotient_o (core_quotient), .status_o (core_status)
  );

  divq_pipe_regs #(.Width(OutW), .NumRegs(NumOutRegs)) u_out_pipe (
    .clk_i, .rst_ni, .flush_i,
    .in_valid_i (res_valid), .in_ready_o (res_ready),
    .in_data_i  ({res_quotient, res_status, res_tag}),
    .out_valid_o, .out_ready_i,
    .out_data_o (out_data),
    .any_valid_o (out_any)
  );
  assign {quotient_o, status_o, tag_o} = out_data;

  // Anything in flight in pipes or control
  assign busy_o = inp_any | ctrl_busy | out_any;

endmodule

// File: list.f
+incdir+.
divq_pkg.sv
divq_pipe_regs.sv
divq_core.sv
divq_ctrl.sv
divq_top.sv
divq_assert.sv
divq_tb_clk.sv
divq_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the divider testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert -Wno-fatal --top-module divq_tb \
    -f list.f --Mdir "$OBJ" -o divq_sim; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/divq_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

# The testbench reports its verdict in the log
if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0
